//--- logic/data_memory.sv
module data_memory
  import regmem_pkg::*;
#(
  parameter int MEM_AW = 8
) (
  input  logic              clk,
  input  logic              en,
  input  logic              we,
  input  logic [MEM_AW-1:0] addr,
  input  logic [data_w-1:0] wdata,
  output logic [data_w-1:0] rdata
);

  localparam int depth = 1 << MEM_AW;

  // register images, contents undefined until written
  logic [data_w-1:0] mem [depth];

  // single port, read before write
  // rdata valid the cycle after en
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

//--- logic/operand_engine.sv
module operand_engine
  import regmem_pkg::*;
#(
  parameter int MEM_AW = 8
) (
  input  logic              clk,
  input  logic              rst,
  // command from config block
  input  logic              start,
  input  reg_op_e           op,
  input  logic [3:0]        reg_num,
  input  adj_e              adj,
  input  logic [MEM_AW-1:0] base_addr,
  input  logic [data_w-1:0] wdata,
  // status back to config block
  output logic              busy,
  output logic              done,
  output logic [data_w-1:0] result,
  output logic [data_w-1:0] ptr,
  // data memory port
  output logic              mem_en,
  output logic              mem_we,
  output logic [MEM_AW-1:0] mem_addr,
  output logic [data_w-1:0] mem_wdata,
  input  logic [data_w-1:0] mem_rdata
);

  eng_state_e        state;
  reg_op_e           op_q;
  logic              is_write;
  logic              is_ptr_op;
  logic [MEM_AW-1:0] addr_next;
  logic [data_w-1:0] wr_value;
  logic              go;

  // only accepted from idle
  assign go = (state == st_idle) && start;

  assign busy = (state != st_idle);
  // one cycle pulse, st_done lasts a single cycle
  assign done = (state == st_done);

  assign is_write  = (op == op_write) || (op == op_write_p);
  assign is_ptr_op = (op == op_read_p) || (op == op_write_p);

  // base plus reg number, or base plus captured pointer
  // sum wraps modulo memory size
  always_comb begin
    if (is_ptr_op) begin
      addr_next = base_addr + ptr[MEM_AW-1:0];
    end else begin
      addr_next = base_addr + MEM_AW'(reg_num);
    end
  end

  // post inc/dec only on direct write
  always_comb begin
    wr_value = wdata;
    if (op == op_write) begin
      case (adj)
        adj_inc: wr_value = wdata + 1'b1;
        adj_dec: wr_value = wdata - 1'b1;
        // code 11 behaves as none
        default: wr_value = wdata;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      op_q   <= op_read;
      mem_en <= 1'b0;
      mem_we <= 1'b0;
      result <= '0;
      ptr    <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            // access goes out the cycle after start
            op_q   <= op;
            mem_en <= 1'b1;
            mem_we <= is_write;
            state  <= st_issue;
          end
        end
        st_issue: begin
          mem_en <= 1'b0;
          mem_we <= 1'b0;
          // writes finish here, reads wait for rdata
          if (op_q == op_write || op_q == op_write_p) begin
            state <= st_done;
          end else begin
            state <= st_wait;
          end
        end
        st_wait: begin
          result <= mem_rdata;
          // direct read also loads the pointer
          if (op_q == op_read) ptr <= mem_rdata;
          state <= st_done;
        end
        st_done: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // address and data for the access
  always_ff @(posedge clk) begin
    if (go) begin
      mem_addr  <= addr_next;
      mem_wdata <= wr_value;
    end
  end

endmodule

//--- logic/regmem_csr.sv
module regmem_csr
  import regmem_pkg::*;
#(
  parameter int MEM_AW = 8
) (
  input  logic              clk,
  input  logic              rst,
  // axi4-lite slave
  input  logic [7:0]        awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [data_w-1:0] wdata_axi,
  input  logic [3:0]        wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [7:0]        araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [data_w-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  // engine side
  output logic              start,
  output reg_op_e           op,
  output logic [3:0]        reg_num,
  output adj_e              adj,
  output logic [MEM_AW-1:0] base_addr,
  output logic [data_w-1:0] wdata,
  input  logic              busy,
  input  logic              done,
  input  logic [data_w-1:0] result,
  input  logic [data_w-1:0] ptr
);

  logic              aw_held;
  logic              w_held;
  logic [7:0]        aw_addr_q;
  logic [data_w-1:0] w_data_q;
  logic              aw_hs;
  logic              w_hs;
  logic              ar_hs;
  logic              wr_fire;
  logic [7:0]        wr_addr;
  logic [data_w-1:0] wr_data;
  logic [data_w-1:0] cmd_q;
  logic              done_sticky;
  logic [data_w-1:0] rd_mux;

  // one outstanding response per channel
  assign awready = !aw_held && !bvalid;
  assign wready  = !w_held && !bvalid;
  assign arready = !rvalid;
  assign bresp   = resp_okay;
  assign rresp   = resp_okay;

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;
  assign ar_hs = arvalid && arready;

  // write commits once both address and data are in
  assign wr_fire = (aw_held || aw_hs) && (w_held || w_hs);
  assign wr_addr = aw_held ? aw_addr_q : awaddr;
  assign wr_data = w_held ? w_data_q : wdata_axi;

  // command fields out to engine
  assign op      = reg_op_e'(cmd_q[cmd_op_lsb +: 2]);
  assign reg_num = cmd_q[cmd_reg_lsb +: 4];
  assign adj     = adj_e'(cmd_q[cmd_adj_lsb +: 2]);

  // park a lone aw or w until its partner shows up
  always_ff @(posedge clk) begin
    if (rst) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      if (wr_fire) begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
        bvalid  <= 1'b1;
      end else begin
        if (aw_hs) aw_held <= 1'b1;
        if (w_hs) w_held <= 1'b1;
        if (bready) bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) aw_addr_q <= awaddr;
    if (w_hs) w_data_q <= wdata_axi;
  end

  // config registers, start pulse, sticky done
  always_ff @(posedge clk) begin
    if (rst) begin
      base_addr   <= '0;
      cmd_q       <= '0;
      wdata       <= '0;
      start       <= 1'b0;
      done_sticky <= 1'b0;
    end else begin
      start <= 1'b0;
      if (done) done_sticky <= 1'b1;
      if (wr_fire) begin
        // strobes ignored, full word written
        case (wr_addr[7:2])
          csr_ctrl[7:2]: begin
            // start while busy is dropped
            if (wr_data[ctrl_start_bit] && !busy) begin
              start       <= 1'b1;
              done_sticky <= 1'b0;
            end
          end
          csr_base[7:2]:  base_addr <= wr_data[MEM_AW-1:0];
          csr_cmd[7:2]:   cmd_q <= wr_data;
          csr_wdata[7:2]: wdata <= wr_data;
          // status, result, ptr are read only
          default: ;
        endcase
      end
    end
  end

  // read map, unmapped and ctrl read zero
  always_comb begin
    rd_mux = '0;
    case (araddr[7:2])
      csr_status[7:2]: begin
        rd_mux[stat_busy_bit] = busy;
        rd_mux[stat_done_bit] = done_sticky;
      end
      csr_base[7:2]:   rd_mux = {{(data_w - MEM_AW){1'b0}}, base_addr};
      csr_cmd[7:2]:    rd_mux = cmd_q;
      csr_wdata[7:2]:  rd_mux = wdata;
      csr_result[7:2]: rd_mux = result;
      csr_ptr[7:2]:    rd_mux = ptr;
      default:         rd_mux = '0;
    endcase
  end

  // read data one cycle after ar, held till rready
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
      rdata  <= '0;
    end else if (ar_hs) begin
      rvalid <= 1'b1;
      rdata  <= rd_mux;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

endmodule

//--- logic/regmem_pkg.sv
package regmem_pkg;

  // register and bus word width
  localparam int data_w = 32;

  // register access opcodes, cmd bits 1:0
  typedef enum logic [1:0] {
    op_read    = 2'b00,
    op_read_p  = 2'b01,
    op_write   = 2'b10,
    op_write_p = 2'b11
  } reg_op_e;

  // post adjust on written value, cmd bits 9:8
  typedef enum logic [1:0] {
    adj_none = 2'b00,
    adj_inc  = 2'b01,
    adj_dec  = 2'b10
  } adj_e;

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait,
    st_done
  } eng_state_e;

  // register map, byte offsets
  localparam logic [7:0] csr_ctrl   = 8'h00;
  localparam logic [7:0] csr_status = 8'h04;
  localparam logic [7:0] csr_base   = 8'h08;
  localparam logic [7:0] csr_cmd    = 8'h0C;
  localparam logic [7:0] csr_wdata  = 8'h10;
  localparam logic [7:0] csr_result = 8'h14;
  localparam logic [7:0] csr_ptr    = 8'h18;

  // command word fields
  localparam int cmd_op_lsb  = 0;
  localparam int cmd_reg_lsb = 4;
  localparam int cmd_adj_lsb = 8;

  // ctrl and status bits
  localparam int ctrl_start_bit = 0;
  localparam int stat_busy_bit  = 0;
  localparam int stat_done_bit  = 1;

  localparam logic [1:0] resp_okay = 2'b00;

endpackage

//--- logic/regmem_top.sv
module regmem_top
  import regmem_pkg::*;
#(
  parameter int MEM_AW = 8
) (
  input  logic              clk,
  input  logic              rst,
  // axi4-lite config port
  input  logic [7:0]        awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [data_w-1:0] wdata_axi,
  input  logic [3:0]        wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [7:0]        araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [data_w-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready
);

  // config block to engine
  logic              start;
  reg_op_e           op;
  logic [3:0]        reg_num;
  adj_e              adj;
  logic [MEM_AW-1:0] base_addr;
  logic [data_w-1:0] eng_wdata;
  logic              busy;
  logic              done;
  logic [data_w-1:0] result;
  logic [data_w-1:0] ptr;

  // engine to memory
  logic              mem_en;
  logic              mem_we;
  logic [MEM_AW-1:0] mem_addr;
  logic [data_w-1:0] mem_wdata;
  logic [data_w-1:0] mem_rdata;

  regmem_csr #(
    .MEM_AW(MEM_AW)
  ) u_csr (
    .clk       (clk),
    .rst       (rst),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata_axi (wdata_axi),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .start     (start),
    .op        (op),
    .reg_num   (reg_num),
    .adj       (adj),
    .base_addr (base_addr),
    .wdata     (eng_wdata),
    .busy      (busy),
    .done      (done),
    .result    (result),
    .ptr       (ptr)
  );

  operand_engine #(
    .MEM_AW(MEM_AW)
  ) u_engine (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .op        (op),
    .reg_num   (reg_num),
    .adj       (adj),
    .base_addr (base_addr),
    .wdata     (eng_wdata),
    .busy      (busy),
    .done      (done),
    .result    (result),
    .ptr       (ptr),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  data_memory #(
    .MEM_AW(MEM_AW)
  ) u_mem (
    .clk   (clk),
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_regmem -f vlog.f -o sim_regmem ||
  { echo "build failed"; exit 1; }
./obj_dir/sim_regmem > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed"

//--- testbench/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// host side of the config port
// drives land 1 ns after a rising edge, ready and valid sampled at the falling edge

// single write, bready held low for hold_b cycles once bvalid is up
task automatic axil_write(input logic [7:0] addr, input logic [data_w-1:0] data,
                          input int hold_b);
  int n;
  awaddr    = addr;
  awvalid   = 1'b1;
  wdata_axi = data;
  wstrb     = 4'hf;
  wvalid    = 1'b1;
  bready    = (hold_b == 0);
  n = 0;
  @(negedge clk);
  while (!(awready && wready)) begin
    n++;
    if (n > tmo) abort_run("timeout, write address and data never accepted");
    @(negedge clk);
  end
  // handshake on this edge
  @(posedge clk);
  #1;
  awvalid = 1'b0;
  wvalid  = 1'b0;
  n = 0;
  @(negedge clk);
  while (!bvalid) begin
    n++;
    if (n > tmo) abort_run("timeout, write response never arrived");
    @(negedge clk);
  end
  check_val("bresp", 32'(resp_okay), 32'(bresp));
  if (hold_b > 0) begin
    repeat (hold_b) @(posedge clk);
    #1;
    // response still pending without bready
    check_val("bvalid_held", 32'd1, 32'(bvalid));
    bready = 1'b1;
  end
  @(posedge clk);
  #1;
  if (hold_b > 0) check_val("bvalid_clear", 32'd0, 32'(bvalid));
endtask

// single read, rready kept high
task automatic axil_read(input logic [7:0] addr, output logic [data_w-1:0] data);
  int n;
  araddr  = addr;
  arvalid = 1'b1;
  n = 0;
  @(negedge clk);
  while (!arready) begin
    n++;
    if (n > tmo) abort_run("timeout, read address never accepted");
    @(negedge clk);
  end
  @(posedge clk);
  #1;
  arvalid = 1'b0;
  n = 0;
  @(negedge clk);
  while (!rvalid) begin
    n++;
    if (n > tmo) abort_run("timeout, read data never arrived");
    @(negedge clk);
  end
  data = rdata;
  check_val("rresp", 32'(resp_okay), 32'(rresp));
  @(posedge clk);
  #1;
endtask

// poll status until the sticky done bit shows up
task automatic poll_done(output logic [data_w-1:0] status);
  int n;
  n = 0;
  axil_read(csr_status, status);
  while (!status[stat_done_bit]) begin
    n++;
    if (n > tmo) abort_run("timeout, engine done bit never set");
    axil_read(csr_status, status);
  end
  // done and idle, busy gone
  check_val("status_done", 32'h2, status);
endtask

`endif

//--- testbench/tb_regmem.sv
module tb_regmem
  import regmem_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // limit per wait loop in cycles or polls
  localparam int tmo = 64;

  logic              clk;
  logic              rst;
  logic [7:0]        awaddr;
  logic              awvalid;
  logic              awready;
  logic [data_w-1:0] wdata_axi;
  logic [3:0]        wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [7:0]        araddr;
  logic              arvalid;
  logic              arready;
  logic [data_w-1:0] rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  int    seed;
  int    errors;
  int    checks;
  int    tests;
  int    test_errors0;
  string cur_test;

  // reference model of memory image, pointer and last read result
  logic [data_w-1:0] model_mem [256];
  logic [data_w-1:0] model_ptr;
  logic [data_w-1:0] model_result;

  // 8 ns period
  always #4 clk = ~clk;

  regmem_top #(
    .MEM_AW(8)
  ) dut (
    .clk       (clk),
    .rst       (rst),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata_axi (wdata_axi),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready)
  );

  task automatic check_val(input string name, input logic [data_w-1:0] exp,
                           input logic [data_w-1:0] act);
    checks++;
    assert (act === exp)
    else begin
      $display("ERR %s/%s expected %08h actual %08h", cur_test, name, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test     = name;
    test_errors0 = errors;
    tests++;
  endtask

  task automatic end_test();
    if (errors == test_errors0) begin
      $display("%-8s pass", cur_test);
    end else begin
      $display("%-8s fail, %0d errors", cur_test, errors - test_errors0);
    end
  endtask

  task automatic end_run();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  task automatic abort_run(input string what);
    $display("%s: %s", cur_test, what);
    errors++;
    end_test();
    end_run();
  endtask

  `include "tb_axil_tasks.svh"

  // initial image uses every bit of the address
  function automatic logic [data_w-1:0] fill_word(input logic [7:0] a);
    return {a, ~a, a ^ 8'h3c, a + 8'h11};
  endfunction

  // opcode and adjust rules applied to the model
  task automatic model_op(input reg_op_e op, input logic [3:0] rn, input adj_e aj,
                          input logic [7:0] base, input logic [data_w-1:0] data);
    logic [7:0]        a;
    logic [data_w-1:0] v;
    // pointer ops use the low pointer byte and wrap mod 256
    if (op == op_read_p || op == op_write_p) begin
      a = base + model_ptr[7:0];
    end else begin
      a = base + {4'd0, rn};
    end
    v = data;
    // adjust only on direct write
    if (op == op_write && aj == adj_inc) v = data + 32'd1;
    if (op == op_write && aj == adj_dec) v = data - 32'd1;
    case (op)
      op_read: begin
        model_result = model_mem[a];
        model_ptr    = model_mem[a];
      end
      op_read_p: model_result = model_mem[a];
      default:   model_mem[a] = v;
    endcase
  endtask

  task automatic start_op(input reg_op_e op, input logic [3:0] rn, input adj_e aj,
                          input logic [7:0] base, input logic [data_w-1:0] data);
    axil_write(csr_base, {24'd0, base}, 0);
    axil_write(csr_cmd, {22'd0, aj, rn, 2'd0, op}, 0);
    axil_write(csr_wdata, data, 0);
    axil_write(csr_ctrl, 32'd1, 0);
  endtask

  task automatic finish_op();
    logic [data_w-1:0] res;
    logic [data_w-1:0] pr;
    axil_read(csr_result, res);
    axil_read(csr_ptr, pr);
    check_val("result", model_result, res);
    check_val("ptr", model_ptr, pr);
  endtask

  task automatic run_op(input reg_op_e op, input logic [3:0] rn, input adj_e aj,
                        input logic [7:0] base, input logic [data_w-1:0] data);
    logic [data_w-1:0] st;
    start_op(op, rn, aj, base, data);
    poll_done(st);
    model_op(op, rn, aj, base, data);
    finish_op();
  endtask

  task automatic test_reset();
    logic [data_w-1:0] r;
    begin_test("reset");
    check_val("ready_idle", 32'h7, {29'd0, awready, wready, arready});
    check_val("valid_idle", 32'h0, {30'd0, bvalid, rvalid});
    axil_read(csr_status, r);
    check_val("status", 32'd0, r);
    axil_read(csr_result, r);
    check_val("result", 32'd0, r);
    axil_read(csr_ptr, r);
    check_val("ptr", 32'd0, r);
    end_test();
  endtask

  // write every word once as the memory has no reset
  task automatic fill_memory();
    int         i;
    logic [7:0] a;
    begin_test("fill");
    for (i = 0; i < 256; i++) begin
      a = 8'(i);
      run_op(op_write, a[3:0], adj_none, {a[7:4], 4'h0}, fill_word(a));
    end
    end_test();
  endtask

  task automatic test_direct();
    logic [data_w-1:0] r;
    logic [data_w-1:0] d;
    begin_test("direct");
    repeat (20) begin
      r = $random(seed);
      d = $random(seed);
      run_op(op_write, r[3:0], adj_none, r[15:8], d);
      run_op(op_read, r[3:0], adj_none, r[15:8], 32'd0);
    end
    end_test();
  endtask

  task automatic test_adjust();
    logic [data_w-1:0] d;
    logic [3:0]        rn;
    begin_test("adjust");
    // wrap at all ones and at zero
    run_op(op_write, 4'd1, adj_inc, 8'h80, 32'hffff_ffff);
    run_op(op_read, 4'd1, adj_none, 8'h80, 32'd0);
    run_op(op_write, 4'd2, adj_dec, 8'h80, 32'd0);
    run_op(op_read, 4'd2, adj_none, 8'h80, 32'd0);
    repeat (8) begin
      d  = $random(seed);
      rn = 4'($random(seed));
      run_op(op_write, rn, adj_inc, 8'h90, d);
      run_op(op_read, rn, adj_none, 8'h90, 32'd0);
      run_op(op_write, rn, adj_dec, 8'h90, d);
      run_op(op_read, rn, adj_none, 8'h90, 32'd0);
    end
    end_test();
  endtask

  task automatic test_pointer();
    logic [data_w-1:0] pw;
    logic [data_w-1:0] d;
    logic [7:0]        b;
    begin_test("pointer");
    repeat (8) begin
      pw = $random(seed);
      d  = $random(seed);
      b  = 8'($random(seed));
      // both high so base plus pointer wraps past 255
      b[7]  = 1'b1;
      pw[7] = 1'b1;
      run_op(op_write, 4'd9, adj_none, 8'h10, pw);
      run_op(op_read, 4'd9, adj_none, 8'h10, 32'd0);
      // adjust code has no effect on pointer writes
      run_op(op_write_p, 4'd0, adj_inc, b, d);
      run_op(op_read_p, 4'd0, adj_none, b, 32'd0);
      // direct read of the wrapped base plus pointer location
      run_op(op_read, 4'd0, adj_none, b + pw[7:0], 32'd0);
    end
    end_test();
  endtask

  task automatic test_status();
    logic [data_w-1:0] st;
    logic [data_w-1:0] d;
    begin_test("status");
    // done from the last op is cleared by this start
    start_op(op_read, 4'd5, adj_none, 8'h40, 32'd0);
    axil_read(csr_status, st);
    check_val("busy_after_start", 32'h1, st);
    poll_done(st);
    model_op(op_read, 4'd5, adj_none, 8'h40, 32'd0);
    repeat (2) begin
      axil_read(csr_status, st);
      check_val("done_sticky", 32'h2, st);
    end
    finish_op();
    // retarget as a write of reg 6 and start again while busy
    d = ~model_mem[8'h46];
    start_op(op_read, 4'd5, adj_none, 8'h40, d);
    axil_write(csr_cmd, {22'd0, adj_none, 4'd6, 2'd0, op_write}, 0);
    axil_write(csr_ctrl, 32'd1, 0);
    poll_done(st);
    model_op(op_read, 4'd5, adj_none, 8'h40, d);
    finish_op();
    // reg 6 keeps its old word
    run_op(op_read, 4'd6, adj_none, 8'h40, 32'd0);
    end_test();
  endtask

  task automatic test_axil();
    logic [data_w-1:0] v;
    logic [data_w-1:0] r;
    begin_test("axil");
    v = $random(seed);
    axil_write(csr_base, v, 0);
    axil_read(csr_base, r);
    // only the memory address bits are kept
    check_val("base_rb", {24'd0, v[7:0]}, r);
    v = $random(seed);
    axil_write(csr_cmd, v, 0);
    axil_read(csr_cmd, r);
    check_val("cmd_rb", v, r);
    v = $random(seed);
    axil_write(csr_wdata, v, 0);
    axil_read(csr_wdata, r);
    check_val("wdata_rb", v, r);
    axil_read(8'h1c, r);
    check_val("unmapped_1c", 32'd0, r);
    axil_read(8'hfc, r);
    check_val("unmapped_fc", 32'd0, r);
    // result and ptr are read only
    axil_write(csr_result, ~model_result, 0);
    axil_read(csr_result, r);
    check_val("result_ro", model_result, r);
    axil_write(csr_ptr, ~model_ptr, 0);
    axil_read(csr_ptr, r);
    check_val("ptr_ro", model_ptr, r);
    // write still lands with a slow bready
    v = $random(seed);
    axil_write(csr_wdata, v, 3);
    axil_read(csr_wdata, r);
    check_val("wdata_slow_b", v, r);
    end_test();
  endtask

  task automatic test_random(input int n_ops);
    logic [data_w-1:0] r;
    adj_e              aj;
    begin_test("random");
    repeat (n_ops) begin
      r  = $random(seed);
      aj = adj_e'(r[9:8]);
      // code 11 is no defined adjust
      if (r[9:8] == 2'b11) aj = adj_none;
      run_op(reg_op_e'(r[1:0]), r[7:4], aj, r[23:16], $random(seed));
    end
    end_test();
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata_axi    = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b1;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b1;
    seed         = 32'ha3df27ad;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    cur_test     = "init";
    model_ptr    = '0;
    model_result = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset();
    fill_memory();
    test_direct();
    test_adjust();
    test_pointer();
    test_status();
    test_axil();
    test_random(200);
    end_run();
  end

endmodule

//--- vlog.f
+incdir+testbench
logic/regmem_pkg.sv
logic/regmem_csr.sv
logic/operand_engine.sv
logic/data_memory.sv
logic/regmem_top.sv
testbench/tb_regmem.sv
